/* source/pool_settings.svh */
// pooling stage settings
// lane count, data widths, map geometry and output port sizes
`ifndef POOL_SETTINGS_SVH
`define POOL_SETTINGS_SVH

// lanes and per-lane widths
`define POOL_NUM_LANES      8
`define POOL_PSUM_WIDTH     28
`define POOL_DATA_WIDTH     8
`define POOL_SLICE_WIDTH    7

// fixed-point slicing
`define POOL_FL_MAX         21
`define POOL_FL_WIDTH       5

// partial-sum map, side must divide by 2 and 3
`define POOL_MAP_LEN        12
`define POOL_ADDR_WIDTH     8

// output buffers
`define POOL_PORT_WIDTH     32
`define POOL_OUT_ADDR_WIDTH 10

`endif

/* source/pool_pkg.sv */
// pooling stage types
// controller states, configuration word and lane buses
`include "pool_settings.svh"

package pool_pkg;

    // ======================================================================
    // controller states
    // ======================================================================
    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0,
        ST_START = 3'd1,
        ST_READ  = 3'd2,
        ST_WAIT  = 3'd3,
        ST_DRAIN = 3'd4
    } pool_state_e;

    // ======================================================================
    // configuration and buses
    // ======================================================================
    // stride is 2 or 3
    typedef struct packed {
        logic [`POOL_FL_WIDTH-1:0] frac_len;
        logic [1:0]                stride;
    } pool_cfg_t;

    // one partial sum per lane
    typedef logic [`POOL_NUM_LANES-1:0][`POOL_PSUM_WIDTH-1:0] psum_bus_t;

    // one pooled value per lane
    typedef logic [`POOL_NUM_LANES-1:0][`POOL_DATA_WIDTH-1:0] lane_vals_t;

endpackage

/* source/pool_window_ctrl.sv */
// pooling window controller
// walks stride x stride windows in raster order and issues partial-sum reads
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_window_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  pool_pkg::pool_cfg_t         cfg,
    input  logic                        pool_en,
    input  logic                        enc_busy,
    output logic                        psum_rd,
    output logic [`POOL_ADDR_WIDTH-1:0] psum_addr,
    output logic                        acc_clr,
    output logic                        acc_en,
    output logic                        win_done
);

    localparam int AW = `POOL_ADDR_WIDTH;
    localparam logic [AW-1:0] MAP_LEN  = AW'(`POOL_MAP_LEN);
    localparam logic [AW-1:0] MAP_AREA = AW'(`POOL_MAP_LEN * `POOL_MAP_LEN);

    pool_pkg::pool_state_e state;
    pool_pkg::pool_state_e next_state;

    logic [1:0]    cnt_x;
    logic [1:0]    cnt_y;
    logic [AW-1:0] col_base;
    logic [AW-1:0] row_base;
    logic [AW-1:0] stride_a;
    logic [AW-1:0] row_step;
    logic          win_last_rd;
    logic          row_end;
    logic          pass_end;
    logic          adv_win;

    // ======================================================================
    // window geometry
    // ======================================================================
    assign stride_a    = AW'(cfg.stride);
    assign row_step    = MAP_LEN * stride_a;
    assign win_last_rd = (cnt_x == cfg.stride - 2'd1) && (cnt_y == cfg.stride - 2'd1);
    assign row_end     = (col_base + stride_a) >= MAP_LEN;
    assign pass_end    = row_end && ((row_base + row_step) >= MAP_AREA);
    // encoder has drained the finished window
    assign adv_win     = (state == pool_pkg::ST_DRAIN) && !enc_busy;

    // ======================================================================
    // state machine
    // ======================================================================
    always_comb begin
        next_state = state;
        case (state)
            pool_pkg::ST_IDLE:  if (pool_en) next_state = pool_pkg::ST_START;
            pool_pkg::ST_START: next_state = pool_pkg::ST_READ;
            pool_pkg::ST_READ:  if (win_last_rd) next_state = pool_pkg::ST_WAIT;
            pool_pkg::ST_WAIT:  next_state = pool_pkg::ST_DRAIN;
            pool_pkg::ST_DRAIN: begin
                if (!enc_busy) begin
                    next_state = pass_end ? pool_pkg::ST_IDLE : pool_pkg::ST_START;
                end
            end
            default:            next_state = pool_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pool_pkg::ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // x runs fastest inside the window
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_x <= 2'd0;
            cnt_y <= 2'd0;
        end else if (state == pool_pkg::ST_READ) begin
            if (cnt_x == cfg.stride - 2'd1) begin
                cnt_x <= 2'd0;
                cnt_y <= (cnt_y == cfg.stride - 2'd1) ? 2'd0 : cnt_y + 2'd1;
            end else begin
                cnt_x <= cnt_x + 2'd1;
            end
        end
    end

    // window base steps by stride across the row, then down a stripe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_base <= '0;
            row_base <= '0;
        end else if (state == pool_pkg::ST_IDLE) begin
            col_base <= '0;
            row_base <= '0;
        end else if (adv_win && !pass_end) begin
            if (row_end) begin
                col_base <= '0;
                row_base <= row_base + row_step;
            end else begin
                col_base <= col_base + stride_a;
            end
        end
    end

    // data comes back one cycle after the read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_en   <= 1'b0;
            win_done <= 1'b0;
        end else begin
            acc_en   <= psum_rd;
            win_done <= (state == pool_pkg::ST_WAIT);
        end
    end

    assign psum_rd   = (state == pool_pkg::ST_READ);
    assign psum_addr = row_base + col_base + AW'(cnt_x) + MAP_LEN * AW'(cnt_y);
    assign acc_clr   = (state == pool_pkg::ST_START);

    a_legal_stride: assert property (@(posedge clk) disable iff (!rst_n)
        pool_en |-> (cfg.stride == 2'd2 || cfg.stride == 2'd3));

endmodule

/* source/pool_lane.sv */
// pooling lane
// relu, fixed-point slice and running window maximum for one lane
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_lane (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [`POOL_FL_WIDTH-1:0]    frac_len,
    input  logic [`POOL_PSUM_WIDTH-1:0]  psum,
    input  logic                         acc_clr,
    input  logic                         acc_en,
    output logic [`POOL_DATA_WIDTH-1:0]  pooled
);

    localparam int FW = `POOL_FL_WIDTH;
    localparam int PW = `POOL_PSUM_WIDTH;
    localparam int DW = `POOL_DATA_WIDTH;
    localparam int SW = `POOL_SLICE_WIDTH;
    localparam logic [FW-1:0] FL_MAX = FW'(`POOL_FL_MAX);

    logic [FW-1:0] fl_clamp;
    logic [PW-1:0] relu;
    logic [SW-1:0] slice;
    logic [DW-1:0] cand;

    // clamp keeps the slice inside the partial sum
    assign fl_clamp = (frac_len > FL_MAX) ? FL_MAX : frac_len;

    // negative sums pool as zero
    assign relu = psum[PW-1] ? '0 : psum;

    // upper bits dropped, no saturation
    assign slice = relu[fl_clamp +: SW];
    assign cand  = DW'(slice);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pooled <= '0;
        end else if (acc_clr) begin
            pooled <= '0;
        end else if (acc_en && (cand > pooled)) begin
            pooled <= cand;
        end
    end

endmodule

/* source/pool_sparse_enc.sv */
// sparse encoder for finished windows
// emits the lane flag vector, then scans out nonzero values in lane order
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_sparse_enc (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        win_done,
    input  pool_pkg::lane_vals_t        lane_vals,
    input  logic                        val_ready,
    output logic                        enc_busy,
    output logic                        flag_push,
    output logic [`POOL_NUM_LANES-1:0]  flag_vec,
    output logic                        val_push,
    output logic [`POOL_DATA_WIDTH-1:0] val_item
);

    localparam int N  = `POOL_NUM_LANES;
    localparam int IW = $clog2(N);
    localparam logic [IW-1:0] LAST_LANE = IW'(N - 1);

    pool_pkg::lane_vals_t vals_q;
    logic [N-1:0]         lane_nz;
    logic [IW-1:0]        lane_idx;
    logic                 scanning;
    logic                 cur_nz;
    logic                 step;

    // ======================================================================
    // window capture
    // ======================================================================
    always_comb begin
        for (int i = 0; i < N; i++) begin
            lane_nz[i] = |lane_vals[i];
        end
    end

    always_ff @(posedge clk) begin
        if (win_done) begin
            vals_q <= lane_vals;
        end
    end

    // ======================================================================
    // lane scan
    // ======================================================================
    assign cur_nz = flag_vec[lane_idx];

    // zero lanes pass in one cycle, nonzero lanes wait for the packer
    assign step     = scanning && (!cur_nz || val_ready);
    assign val_push = scanning && cur_nz && val_ready;
    assign val_item = vals_q[lane_idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_push <= 1'b0;
            flag_vec  <= '0;
            scanning  <= 1'b0;
            lane_idx  <= '0;
        end else begin
            flag_push <= win_done;
            if (win_done) begin
                flag_vec <= lane_nz;
                scanning <= 1'b1;
                lane_idx <= '0;
            end else if (step) begin
                if (lane_idx == LAST_LANE) begin
                    scanning <= 1'b0;
                end else begin
                    lane_idx <= lane_idx + 1'b1;
                end
            end
        end
    end

    // busy already in the win_done cycle so the controller holds
    assign enc_busy = scanning || win_done;

    // controller must drain before handing over the next window
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        win_done |-> !scanning);

endmodule

/* source/pool_packer.sv */
// right-aligned packer
// gathers narrow items into port-width words, first item in the low bits
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_packer #(
    parameter int IN_WIDTH  = 8,
    parameter int OUT_WIDTH = 32
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            push,
    input  logic [IN_WIDTH-1:0]             item,
    input  logic                            busy,
    output logic                            ready,
    output logic                            wr,
    output logic [`POOL_OUT_ADDR_WIDTH-1:0] addr,
    output logic [OUT_WIDTH-1:0]            word
);

    localparam int ITEMS = OUT_WIDTH / IN_WIDTH;
    localparam int CW    = $clog2(ITEMS + 1);
    localparam logic [CW-1:0] FULL_CNT = CW'(ITEMS);

    logic [CW-1:0] fill_cnt;

    // full word held until the buffer frees up
    assign ready = (fill_cnt != FULL_CNT);
    assign wr    = !ready && !busy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_cnt <= '0;
        end else if (wr) begin
            fill_cnt <= '0;
        end else if (push) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // new item enters at the top and walks down
    always_ff @(posedge clk) begin
        if (push) begin
            word <= (word >> IN_WIDTH) | (OUT_WIDTH'(item) << (OUT_WIDTH - IN_WIDTH));
        end
    end

    // address carries on across passes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr <= '0;
        end else if (wr) begin
            addr <= addr + 1'b1;
        end
    end

    a_push_ready: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> ready);

endmodule

/* source/pool_top.sv */
// pooling stage top level
// window controller, per-lane pooling, sparse encoder and output packers
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  pool_pkg::pool_cfg_t             cfg,
    input  logic                            pool_en,
    input  pool_pkg::psum_bus_t             psum_data,
    input  logic                            ofm_busy,
    input  logic                            flag_busy,
    output logic                            psum_rd,
    output logic [`POOL_ADDR_WIDTH-1:0]     psum_addr,
    output logic                            ofm_wr,
    output logic [`POOL_OUT_ADDR_WIDTH-1:0] ofm_addr,
    output logic [`POOL_PORT_WIDTH-1:0]     ofm_data,
    output logic                            flag_wr,
    output logic [`POOL_OUT_ADDR_WIDTH-1:0] flag_addr,
    output logic [`POOL_PORT_WIDTH-1:0]     flag_data
);

    logic                        acc_clr;
    logic                        acc_en;
    logic                        win_done;
    logic                        enc_busy;
    pool_pkg::lane_vals_t        lane_vals;
    logic                        flag_push;
    logic [`POOL_NUM_LANES-1:0]  flag_vec;
    logic                        val_push;
    logic [`POOL_DATA_WIDTH-1:0] val_item;
    logic                        val_ready;

    pool_window_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .pool_en   (pool_en),
        .enc_busy  (enc_busy),
        .psum_rd   (psum_rd),
        .psum_addr (psum_addr),
        .acc_clr   (acc_clr),
        .acc_en    (acc_en),
        .win_done  (win_done)
    );

    // ======================================================================
    // lanes
    // ======================================================================
    for (genvar i = 0; i < `POOL_NUM_LANES; i++) begin : g_lane
        pool_lane u_lane (
            .clk      (clk),
            .rst_n    (rst_n),
            .frac_len (cfg.frac_len),
            .psum     (psum_data[i]),
            .acc_clr  (acc_clr),
            .acc_en   (acc_en),
            .pooled   (lane_vals[i])
        );
    end

    pool_sparse_enc u_enc (
        .clk       (clk),
        .rst_n     (rst_n),
        .win_done  (win_done),
        .lane_vals (lane_vals),
        .val_ready (val_ready),
        .enc_busy  (enc_busy),
        .flag_push (flag_push),
        .flag_vec  (flag_vec),
        .val_push  (val_push),
        .val_item  (val_item)
    );

    // ======================================================================
    // output packers
    // ======================================================================
    pool_packer #(
        .IN_WIDTH  (`POOL_DATA_WIDTH),
        .OUT_WIDTH (`POOL_PORT_WIDTH)
    ) u_val_pack (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (val_push),
        .item  (val_item),
        .busy  (ofm_busy),
        .ready (val_ready),
        .wr    (ofm_wr),
        .addr  (ofm_addr),
        .word  (ofm_data)
    );

    // flag pushes come once per window, spaced by the scan
    pool_packer #(
        .IN_WIDTH  (`POOL_NUM_LANES),
        .OUT_WIDTH (`POOL_PORT_WIDTH)
    ) u_flag_pack (
        .clk   (clk),
        .rst_n (rst_n),
        .push  (flag_push),
        .item  (flag_vec),
        .busy  (flag_busy),
        .ready (),
        .wr    (flag_wr),
        .addr  (flag_addr),
        .word  (flag_data)
    );

endmodule

/* sim/pool_tb.sv */
// pooling stage testbench
// runs passes over random partial-sum maps, checks reads, flag words and value words
`timescale 1ns/10ps
`include "pool_settings.svh"

module pool_tb;

    localparam int CLK_PERIOD = 4;
    localparam int N          = `POOL_NUM_LANES;
    localparam int MAP        = `POOL_MAP_LEN;
    // three stride-2 passes and two stride-3 passes, plus reset and settle time
    localparam int WD_CYCLES  = 3 * (MAP / 2) * (MAP / 2) * (4 + 40)
                              + 2 * (MAP / 3) * (MAP / 3) * (9 + 40) + 1000;

    logic                            clk;
    logic                            rst_n;
    pool_pkg::pool_cfg_t             cfg;
    logic                            pool_en;
    pool_pkg::psum_bus_t             psum_data;
    logic                            ofm_busy;
    logic                            flag_busy;
    logic                            psum_rd;
    logic [`POOL_ADDR_WIDTH-1:0]     psum_addr;
    logic                            ofm_wr;
    logic [`POOL_OUT_ADDR_WIDTH-1:0] ofm_addr;
    logic [`POOL_PORT_WIDTH-1:0]     ofm_data;
    logic                            flag_wr;
    logic [`POOL_OUT_ADDR_WIDTH-1:0] flag_addr;
    logic [`POOL_PORT_WIDTH-1:0]     flag_data;

    logic [`POOL_PSUM_WIDTH-1:0] mem [N][MAP*MAP];
    logic [`POOL_ADDR_WIDTH-1:0] exp_rd_q[$];
    logic [`POOL_PORT_WIDTH-1:0] exp_flag_q[$];
    logic [`POOL_PORT_WIDTH-1:0] exp_ofm_q[$];
    logic [7:0]                  flag_pend[$];
    logic [7:0]                  val_pend[$];
    int   rd_idx;
    int   flag_idx;
    int   ofm_idx;
    int   err_cnt;
    int   test_cnt;
    int   fail_cnt;
    int   bp_left;
    logic idle_phase;
    logic bp_on;

    pool_top pool_top_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ======================================================================
    // partial-sum memory and buffer back-pressure
    // ======================================================================
    always @(posedge clk) begin
        if (psum_rd) begin
            for (int l = 0; l < N; l++) begin
                psum_data[l] <= mem[l][psum_addr];
            end
        end
    end

    // busy stretches stay short so a full flag word drains before the next window
    always @(posedge clk) begin
        if (bp_left != 0) begin
            bp_left <= bp_left - 1;
        end else if (bp_on && !ofm_busy && !flag_busy) begin
            ofm_busy  <= 1'($urandom);
            flag_busy <= 1'($urandom);
            bp_left   <= 1 + $urandom % 6;
        end else begin
            ofm_busy  <= 1'b0;
            flag_busy <= 1'b0;
            bp_left   <= $urandom % 4;
        end
    end

    always @(posedge clk) begin
        if (psum_rd) rd_idx <= rd_idx + 1;
        if (flag_wr) flag_idx <= flag_idx + 1;
        if (ofm_wr) ofm_idx <= ofm_idx + 1;
    end

    // ======================================================================
    // checks
    // ======================================================================
    function automatic void report_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
        $display("FAIL %0t %s got %h expected %h", $time, sig, got, exp);
        err_cnt++;
    endfunction

    function automatic void report_error(string msg);
        $display("ERROR at %0t: %s", $time, msg);
        err_cnt++;
    endfunction

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        idle_phase |-> (!psum_rd && !ofm_wr && !flag_wr && ofm_addr == 0 && flag_addr == 0))
        else report_error("DUT output active before the first pool_en");

    a_rd_range: assert property (@(posedge clk) disable iff (!rst_n)
        psum_rd |-> rd_idx < exp_rd_q.size())
        else report_error("psum_rd high with no read expected");

    a_rd_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (psum_rd && rd_idx < exp_rd_q.size()) |-> psum_addr == exp_rd_q[rd_idx])
        else report_mismatch("psum_addr", $sampled(psum_addr), exp_rd_q[$sampled(rd_idx)]);

    a_flag_range: assert property (@(posedge clk) disable iff (!rst_n)
        flag_wr |-> (!flag_busy && flag_idx < exp_flag_q.size()))
        else report_error("flag_wr while flag_busy high or with no flag word expected");

    a_flag_word: assert property (@(posedge clk) disable iff (!rst_n)
        (flag_wr && flag_idx < exp_flag_q.size()) |-> flag_data == exp_flag_q[flag_idx])
        else report_mismatch("flag_data", $sampled(flag_data), exp_flag_q[$sampled(flag_idx)]);

    a_flag_addr: assert property (@(posedge clk) disable iff (!rst_n)
        flag_wr |-> int'(flag_addr) == flag_idx)
        else report_mismatch("flag_addr", 32'($sampled(flag_addr)), $sampled(flag_idx));

    a_ofm_range: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr |-> (!ofm_busy && ofm_idx < exp_ofm_q.size()))
        else report_error("ofm_wr while ofm_busy high or with no value word expected");

    a_ofm_word: assert property (@(posedge clk) disable iff (!rst_n)
        (ofm_wr && ofm_idx < exp_ofm_q.size()) |-> ofm_data == exp_ofm_q[ofm_idx])
        else report_mismatch("ofm_data", $sampled(ofm_data), exp_ofm_q[$sampled(ofm_idx)]);

    a_ofm_addr: assert property (@(posedge clk) disable iff (!rst_n)
        ofm_wr |-> int'(ofm_addr) == ofm_idx)
        else report_mismatch("ofm_addr", 32'($sampled(ofm_addr)), $sampled(ofm_idx));

    // ======================================================================
    // reference model
    // ======================================================================
    // relu, slice at the clamped fractional length, zero-extended
    function automatic logic [7:0] pooled_value(logic [`POOL_PSUM_WIDTH-1:0] ps, logic [4:0] fl);
        int                          sh;
        logic [`POOL_PSUM_WIDTH-1:0] mag;
        sh  = (fl > `POOL_FL_MAX) ? `POOL_FL_MAX : int'(fl);
        mag = ps[`POOL_PSUM_WIDTH-1] ? '0 : (ps >> sh);
        return 8'(mag[`POOL_SLICE_WIDTH-1:0]);
    endfunction

    // four items per word, first one in the low byte
    task automatic queue_item(input bit is_flag, input logic [7:0] item);
        if (is_flag) begin
            flag_pend.push_back(item);
            if (flag_pend.size() == 4) begin
                exp_flag_q.push_back({flag_pend[3], flag_pend[2], flag_pend[1], flag_pend[0]});
                flag_pend.delete();
            end
        end else begin
            val_pend.push_back(item);
            if (val_pend.size() == 4) begin
                exp_ofm_q.push_back({val_pend[3], val_pend[2], val_pend[1], val_pend[0]});
                val_pend.delete();
            end
        end
    endtask

    task automatic model_pass(input int s, input logic [4:0] fl);
        int         nwin;
        int         base;
        int         a;
        logic [7:0] v;
        logic [7:0] fvec;
        logic [7:0] best [N];
        nwin = MAP / s;
        for (int wy = 0; wy < nwin; wy++) begin
            for (int wx = 0; wx < nwin; wx++) begin
                base = wy * s * MAP + wx * s;
                for (int l = 0; l < N; l++) best[l] = '0;
                for (int y = 0; y < s; y++) begin
                    for (int x = 0; x < s; x++) begin
                        a = base + x + y * MAP;
                        exp_rd_q.push_back(`POOL_ADDR_WIDTH'(a));
                        for (int l = 0; l < N; l++) begin
                            v = pooled_value(mem[l][a], fl);
                            if (v > best[l]) best[l] = v;
                        end
                    end
                end
                for (int l = 0; l < N; l++) fvec[l] = (best[l] != 0);
                queue_item(1'b1, fvec);
                for (int l = 0; l < N; l++) begin
                    if (best[l] != 0) queue_item(1'b0, best[l]);
                end
            end
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    // small lanes hold values below 32, zero after slicing for fl of 5 and up
    task automatic fill_memory(input logic [N-1:0] neg_mask, input logic [N-1:0] small_mask);
        for (int l = 0; l < N; l++) begin
            for (int a = 0; a < MAP * MAP; a++) begin
                mem[l][a] = `POOL_PSUM_WIDTH'($urandom);
                if (neg_mask[l]) mem[l][a][`POOL_PSUM_WIDTH-1] = 1'b1;
                if (small_mask[l]) mem[l][a] = `POOL_PSUM_WIDTH'($urandom % 32);
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    task automatic run_pass(input string name, input logic [1:0] s, input logic [4:0] fl,
                            input bit bp);
        int errs_before;
        errs_before = err_cnt;
        model_pass(int'(s), fl);
        @(posedge clk);
        cfg        <= '{frac_len: fl, stride: s};
        pool_en    <= 1'b1;
        idle_phase <= 1'b0;
        bp_on      <= bp;
        @(posedge clk);
        pool_en <= 1'b0;
        while (rd_idx < exp_rd_q.size() || flag_idx < exp_flag_q.size()
               || ofm_idx < exp_ofm_q.size()) begin
            @(posedge clk);
        end
        // let the last scan finish and the controller fall back to idle
        bp_on <= 1'b0;
        repeat (24) @(posedge clk);
        finish_test(name, errs_before);
    endtask

    initial begin
        void'($urandom(16));
        clk        = 1'b0;
        rst_n      = 1'b0;
        cfg        = '0;
        pool_en    = 1'b0;
        psum_data  = '0;
        ofm_busy   = 1'b0;
        flag_busy  = 1'b0;
        bp_on      = 1'b0;
        bp_left    = 0;
        idle_phase = 1'b1;
        rd_idx     = 0;
        flag_idx   = 0;
        ofm_idx    = 0;
        err_cnt    = 0;
        test_cnt   = 0;
        fail_cnt   = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge clk);
        finish_test("idle after reset", 0);
        fill_memory(8'h00, 8'h00);
        run_pass("stride 2 raster reads, flags and values", 2'd2, 5'd8, 1'b0);
        fill_memory(8'h42, 8'h10);
        run_pass("stride 2 with negative and zero lanes", 2'd2, 5'd5, 1'b0);
        fill_memory(8'h00, 8'h00);
        run_pass("stride 3 with fractional length clamped", 2'd3, 5'd25, 1'b0);
        fill_memory(8'h81, 8'h00);
        run_pass("stride 2 under back-pressure", 2'd2, 5'd10, 1'b1);
        fill_memory(8'h00, 8'h04);
        run_pass("stride 3 under back-pressure", 2'd3, 5'd12, 1'b1);
        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        $display("timeout: watchdog expired after %0d cycles before all passes ended",
                 WD_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* pool_top.f */
+incdir+source
source/pool_pkg.sv
source/pool_window_ctrl.sv
source/pool_lane.sv
source/pool_sparse_enc.sv
source/pool_packer.sv
source/pool_top.sv
sim/pool_tb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = pool_tb
FILELIST   = pool_top.f
OBJ_DIR    = obj_dir
FLAGS      = --binary --timing --assert --timescale 1ns/10ps -Wno-fatal
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/10ps -Wall
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
